// ==== procCore.f ====
+incdir+source
source/isaPkg.sv
source/ctrlPkg.sv
source/instrFetch.sv
source/regDecode.sv
source/aluExecute.sv
source/dataMemory.sv
source/controlFsm.sv
source/procCore.sv
bench/procCore_sva.sv
bench/procCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the procCore testbench with Verilator

verilator --binary --timing --assert --timescale 1ns/1ps -f procCore.f \
  --top-module procCoreTb -o simProcCore
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

# raise the error limit so assertion failures do not stop the run early
./obj_dir/simProcCore +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
exit 1

// ==== bench/procCoreTb.sv ====
`timescale 1ns/1ps
`include "procCore_settings.svh"

module procCoreTb;

  logic          clk;
  logic          rst;
  logic          start;
  logic          progWe;
  logic [7:0]    progAddr;
  isaPkg::wordT  progData;
  isaPkg::wordT  outPort;
  logic          outValid;
  isaPkg::flagsT ccr;
  logic          busy;
  logic          halted;

  integer        seed = 32'ha8b5;
  int            checks = 0;
  int            mismatches = 0;
  int            failures = 0;     // timeouts, lost or extra port words
  logic          timedOut = 1'b0;

  isaPkg::wordT  prog [256];       // current program image
  int            progLen;
  isaPkg::wordT  modelReg [`REG_N];
  isaPkg::wordT  modelMem [`DMEM_DEPTH];
  isaPkg::flagsT modelFlags;
  isaPkg::wordT  expQ [$];         // port words still to come
  isaPkg::wordT  expPort;          // word the port holds between strobes

  procCore i_procCore (.clk(clk), .rst(rst), .start(start), .progWe(progWe),
    .progAddr(progAddr), .progData(progData), .outPort(outPort), .outValid(outValid),
    .ccr(ccr), .busy(busy), .halted(halted));

  bind procCore procCore_sva i_procCoreSva (.clk(clk), .rst(rst), .outValid(outValid),
    .busy(busy), .halted(halted));

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  task automatic checkOut(input isaPkg::wordT got, input isaPkg::wordT exp, input string what);
    checks++;
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkFlags(input isaPkg::flagsT got, input isaPkg::flagsT exp);
    checks++;
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH at %0t ns: ccr got %b expected %b (z n c)", $time, got, exp);
    end
  endtask

  task automatic checkHalt(input logic gotHalted, input logic gotBusy,
                           input logic expHalted, input logic expBusy);
    checks++;
    if (gotHalted !== expHalted || gotBusy !== expBusy)
    begin
      mismatches++;
      $display("MISMATCH at %0t ns: halted/busy got %b%b expected %b%b", $time,
               gotHalted, gotBusy, expHalted, expBusy);
    end
  endtask

  function automatic isaPkg::wordT encR(isaPkg::opcodeT op, isaPkg::regIdxT rd,
                                        isaPkg::regIdxT rs, isaPkg::regIdxT rt);
    return {op, rd, rs, rt, 2'b00};
  endfunction

  function automatic isaPkg::wordT encI(isaPkg::opcodeT op, isaPkg::regIdxT rd,
                                        logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  task automatic addWord(input isaPkg::wordT w);
    prog[progLen] = w;
    progLen++;
  endtask

  // random program heavy on out and ending in hlt
  task automatic genProgram(input int len);
    logic [31:0]    r;
    isaPkg::regIdxT rd;
    isaPkg::regIdxT rs;
    isaPkg::regIdxT rt;
    isaPkg::opcodeT aluOp;
    progLen = 0;
    while (progLen < len)
    begin
      r = $random(seed);
      rd = r[2:0];
      rs = r[5:3];
      rt = r[8:6];
      aluOp = isaPkg::opcodeT'({2'b00, r[23:21]} + 5'd1);  // mov up to shr
      case (r[31:28])
        4'd0, 4'd1, 4'd2: addWord(encI(isaPkg::opLdi, rd, r[16:9]));
        4'd3:             addWord(encI(isaPkg::opAddi, rd, r[16:9]));
        4'd10, 4'd11:     addWord(encR(isaPkg::opOut, 3'd0, rs, 3'd0));
        4'd12:
        begin
          // store then load back through the same address register
          addWord(encR(isaPkg::opSt, rd, rs, 3'd0));
          addWord(encR(isaPkg::opLd, rt, rs, 3'd0));
          addWord(encR(isaPkg::opOut, 3'd0, rt, 3'd0));
        end
        4'd13: addWord(encR(isaPkg::opLd, rd, rs, 3'd0));
        4'd14: addWord(encR(isaPkg::opSt, rd, rs, 3'd0));
        4'd15: addWord({2'b11, r[23:21], r[10:0]});  // unused code acts as nop
        default: addWord(encR(aluOp, rd, rs, rt));
      endcase
    end
    addWord(encR(isaPkg::opHlt, 3'd0, 3'd0, 3'd0));
  endtask

  // reference model state carries over between programs
  task automatic modelRun();
    isaPkg::wordT   w;
    isaPkg::opcodeT op;
    isaPkg::regIdxT rd;
    isaPkg::wordT   a;
    isaPkg::wordT   b;
    isaPkg::wordT   sx;
    logic [16:0]    wide;           // carry in bit 16
    logic           setFlags;
    for (int pc = 0; pc < progLen; pc++)
    begin
      w = prog[pc];
      op = (w[15:11] > 5'd14) ? isaPkg::opNop : isaPkg::opcodeT'(w[15:11]);  // past halt
      rd = w[10:8];
      a = modelReg[w[7:5]];
      b = modelReg[w[4:2]];
      sx = {{8{w[7]}}, w[7:0]};
      wide = '0;
      setFlags = 1'b1;
      case (op)
        isaPkg::opAdd:  wide = {1'b0, a} + {1'b0, b};
        isaPkg::opAddi: wide = {1'b0, modelReg[rd]} + {1'b0, sx};
        isaPkg::opSub:  wide = {1'b0, a} - {1'b0, b};  // borrow lands in bit 16
        isaPkg::opAnd:  wide = {1'b0, a & b};
        isaPkg::opOr:   wide = {1'b0, a | b};
        isaPkg::opNot:  wide = {1'b0, ~a};
        isaPkg::opShl:  wide = {a, 1'b0};
        isaPkg::opShr:  wide = {a[0], 1'b0, a[15:1]};
        default:        setFlags = 1'b0;
      endcase
      if (setFlags)
      begin
        modelReg[rd] = wide[15:0];
        modelFlags.zero = (wide[15:0] == 16'h0000);
        modelFlags.negative = wide[15];
        modelFlags.carry = wide[16];
      end
      case (op)  // no flag change for these
        isaPkg::opMov: modelReg[rd] = a;
        isaPkg::opLdi: modelReg[rd] = sx;
        isaPkg::opLd:  modelReg[rd] = modelMem[a[7:0]];
        isaPkg::opSt:  modelMem[a[7:0]] = modelReg[rd];
        isaPkg::opOut: expQ.push_back(a);
        default: ;
      endcase
      if (op == isaPkg::opHlt)
        break;
    end
  endtask

  task automatic loadProgram();
    for (int i = 0; i < progLen; i++)
    begin
      @(negedge clk);
      progWe = 1'b1;
      progAddr = 8'(i);
      progData = prog[i];
    end
    @(negedge clk);
    progWe = 1'b0;
  endtask

  // start a run and watch the port until halt
  // noisy pokes the load port while the core runs
  task automatic runProgram(input logic noisy);
    int          cycles;
    int          limit;
    logic [31:0] r;
    limit = progLen * 5 + 20;
    cycles = 0;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    checkHalt(halted, busy, 1'b0, 1'b1);  // fetch of the first word
    forever
    begin
      if (outValid)
      begin
        if (expQ.size() == 0)
        begin
          failures++;
          $display("port word %h at %0t ns was not expected by the model", outPort, $time);
        end
        else
        begin
          expPort = expQ.pop_front();
          checkOut(outPort, expPort, "outPort");
        end
      end
      else
        checkOut(outPort, expPort, "held outPort");
      if (halted)
      begin
        progWe = 1'b0;  // must be gone before the load port opens again
        break;
      end
      if (cycles >= limit)
      begin
        failures++;
        timedOut = 1'b1;
        progWe = 1'b0;
        $display("timeout at %0t ns: core did not halt within %0d cycles", $time, limit);
        break;
      end
      if (noisy && busy)
      begin
        r = $random(seed);
        progWe = 1'b1;
        progAddr = {3'b000, r[4:0]};  // lands on the running program
        progData = r[31:16];
      end
      else
        progWe = 1'b0;
      @(negedge clk);
      cycles++;
    end
    if (!timedOut)
    begin
      checkHalt(halted, busy, 1'b1, 1'b0);
      checkFlags(ccr, modelFlags);
      if (expQ.size() != 0)
      begin
        failures++;
        $display("%0d expected port words never appeared", expQ.size());
      end
    end
    expQ.delete();
  endtask

  initial
  begin
    $timeformat(-9, 0, "", 0);
    rst = 1'b1;
    start = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    modelFlags = '0;
    expPort = '0;
    for (int i = 0; i < `REG_N; i++)
      modelReg[i] = '0;
    for (int i = 0; i < `DMEM_DEPTH; i++)
      modelMem[i] = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // quiet core after reset
    checkOut(outPort, '0, "outPort after reset");
    checkFlags(ccr, '0);
    checkHalt(halted, busy, 1'b0, 1'b0);
    checks++;
    if (outValid !== 1'b0)
    begin
      mismatches++;
      $display("MISMATCH at %0t ns: outValid high after reset", $time);
    end

    // first run starts from idle and the rest from halt
    for (int p = 0; p < 10; p++)
    begin
      genProgram(24);
      loadProgram();
      modelRun();
      runProgram(p[0]);
      if (timedOut)
        break;
    end

    $display("checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
             checks, mismatches, failures, i_procCore.i_procCoreSva.assertFails);
    if (mismatches == 0 && failures == 0 && i_procCore.i_procCoreSva.assertFails == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== bench/procCore_sva.sv ====
`timescale 1ns/1ps

module procCore_sva
(
  input logic clk,
  input logic rst,
  input logic outValid,
  input logic busy,
  input logic halted
);

  int assertFails = 0;  // read by the testbench at the end

  // port strobe never stretches
  outValidPulse: assert property (@(posedge clk) disable iff (rst) outValid |=> !outValid)
  else
  begin
    assertFails++;
    $error("outValid stayed high for more than one cycle");
  end

  // running and halted are exclusive
  busyHaltedExcl: assert property (@(posedge clk) disable iff (rst) !(busy && halted))
  else
  begin
    assertFails++;
    $error("busy and halted high together");
  end

  outValidBusy: assert property (@(posedge clk) disable iff (rst) outValid |-> busy)
  else
  begin
    assertFails++;
    $error("outValid high while the core is not busy");
  end

endmodule

// ==== source/procCore.sv ====
`timescale 1ns/1ps

module procCore
(
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  logic          progWe,
  input  logic [7:0]    progAddr,
  input  isaPkg::wordT  progData,
  output isaPkg::wordT  outPort,
  output logic          outValid,
  output isaPkg::flagsT ccr,
  output logic          busy,
  output logic          halted
);

  ctrlPkg::stateT state;
  logic           fetchEn, decodeEn, execEn, memEn, wbEn, pcClear;
  isaPkg::wordT   instr;

  // decode outputs
  isaPkg::opcodeT dOpcode;
  isaPkg::wordT   dOpA, dOpB, dImm;
  isaPkg::regIdxT dRd;
  logic           dRegWrite, dMemRead, dMemWrite, dUseImm, dIsOut, dIsHalt;
  ctrlPkg::wbSelT dWbSel;

  // decode/execute register
  isaPkg::opcodeT idExOpcode;
  isaPkg::wordT   idExOpA, idExOpB, idExImm;
  isaPkg::regIdxT idExRd;
  logic           idExRegWrite, idExMemRead, idExMemWrite, idExUseImm, idExIsOut;
  ctrlPkg::wbSelT idExWbSel;

  // execute/memory register
  isaPkg::wordT   aluOut, exMemAlu, exMemStore;
  isaPkg::regIdxT exMemRd;
  logic           exMemRegWrite, exMemMemRead, exMemMemWrite, exMemIsOut;
  ctrlPkg::wbSelT exMemWbSel;

  // memory/write-back register
  isaPkg::wordT   memRdData, memWbAlu, memWbMem;
  isaPkg::regIdxT memWbRd;
  logic           memWbRegWrite, memWbIsOut;
  ctrlPkg::wbSelT memWbWbSel;

  isaPkg::wordT   wbData;
  isaPkg::wordT   outReg;  // last value sent to the port

  instrFetch i_instrFetch (.clk(clk), .rst(rst), .fetchEn(fetchEn), .pcClear(pcClear),
    .progWe(progWe && !busy), .progAddr(progAddr), .progData(progData), .instr(instr));

  regDecode i_regDecode (.clk(clk), .rst(rst), .instr(instr),
    .wbEn(wbEn && memWbRegWrite), .wbAddr(memWbRd), .wbData(wbData),
    .opcode(dOpcode), .opA(dOpA), .opB(dOpB), .imm(dImm), .rdAddr(dRd),
    .regWrite(dRegWrite), .memRead(dMemRead), .memWrite(dMemWrite), .useImm(dUseImm),
    .isOut(dIsOut), .isHalt(dIsHalt), .wbSel(dWbSel));

  aluExecute i_aluExecute (.clk(clk), .rst(rst), .execEn(execEn), .opcode(idExOpcode),
    .opA(idExOpA), .opB(idExOpB), .imm(idExImm), .useImm(idExUseImm),
    .aluOut(aluOut), .ccr(ccr));

  dataMemory i_dataMemory (.clk(clk), .rst(rst), .memEn(memEn), .memWrite(exMemMemWrite),
    .addr(exMemAlu[7:0]), .wrData(exMemStore), .rdData(memRdData));  // rs low byte

  controlFsm i_controlFsm (.clk(clk), .rst(rst), .start(start), .isHalt(dIsHalt),
    .state(state), .fetchEn(fetchEn), .decodeEn(decodeEn), .execEn(execEn), .memEn(memEn),
    .wbEn(wbEn), .pcClear(pcClear), .busy(busy), .halted(halted));

  // stage control bits, cleared on reset
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      idExRegWrite  <= 1'b0;
      idExMemWrite  <= 1'b0;
      idExIsOut     <= 1'b0;
      exMemRegWrite <= 1'b0;
      exMemMemWrite <= 1'b0;
      exMemIsOut    <= 1'b0;
      memWbRegWrite <= 1'b0;
      memWbIsOut    <= 1'b0;
    end
    else
    begin
      if (decodeEn)
      begin
        idExRegWrite <= dRegWrite;
        idExMemWrite <= dMemWrite;
        idExIsOut    <= dIsOut;
      end
      if (execEn)
      begin
        exMemRegWrite <= idExRegWrite;
        exMemMemWrite <= idExMemWrite;
        exMemIsOut    <= idExIsOut;
      end
      if (memEn)
      begin
        memWbRegWrite <= exMemRegWrite;
        memWbIsOut    <= exMemIsOut;
      end
    end
  end

  // stage payload
  always_ff @(posedge clk)
  begin
    if (decodeEn)
    begin
      idExOpcode  <= dOpcode;
      idExOpA     <= dOpA;
      idExOpB     <= dOpB;  // rd for st and addi
      idExImm     <= dImm;
      idExRd      <= dRd;
      idExMemRead <= dMemRead;
      idExUseImm  <= dUseImm;
      idExWbSel   <= dWbSel;
    end
    if (execEn)
    begin
      exMemAlu     <= aluOut;
      exMemStore   <= idExOpB;
      exMemRd      <= idExRd;
      exMemMemRead <= idExMemRead;
      exMemWbSel   <= idExWbSel;
    end
    if (memEn)
    begin
      memWbAlu   <= exMemAlu;
      memWbRd    <= exMemRd;
      memWbWbSel <= exMemWbSel;
      if (exMemMemRead)
        memWbMem <= memRdData;  // only loads capture the RAM word
    end
  end

  // write-back mux
  assign wbData = (memWbWbSel == ctrlPkg::wbMem) ? memWbMem : memWbAlu;

  // port strobe for one cycle in write-back of an out
  assign outValid = (state == ctrlPkg::stWriteBack) && memWbIsOut;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      outReg <= '0;
    else if (outValid)
      outReg <= wbData;
  end

  assign outPort = outValid ? wbData : outReg;  // new word visible with the strobe

endmodule

// ==== source/controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm
(
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  logic           isHalt,   // from decode
  output ctrlPkg::stateT state,
  output logic           fetchEn,
  output logic           decodeEn,
  output logic           execEn,
  output logic           memEn,
  output logic           wbEn,
  output logic           pcClear,
  output logic           busy,
  output logic           halted
);

  ctrlPkg::stateT nextState;
  logic           haltSeen;  // current instruction is a halt
  logic           stopped;   // idle or halted

  assign stopped = (state == ctrlPkg::stIdle) || (state == ctrlPkg::stHalt);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= ctrlPkg::stIdle;
    else
      state <= nextState;
  end

  // captured while the instruction is in decode
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      haltSeen <= 1'b0;
    else if (decodeEn)
      haltSeen <= isHalt;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      ctrlPkg::stIdle, ctrlPkg::stHalt:
        if (start)
          nextState = ctrlPkg::stFetch;  // start ignored while busy
      ctrlPkg::stFetch:     nextState = ctrlPkg::stDecode;
      ctrlPkg::stDecode:    nextState = ctrlPkg::stExecute;
      ctrlPkg::stExecute:   nextState = ctrlPkg::stMemory;
      ctrlPkg::stMemory:    nextState = ctrlPkg::stWriteBack;
      ctrlPkg::stWriteBack:
        nextState = haltSeen ? ctrlPkg::stHalt : ctrlPkg::stFetch;
      default: nextState = ctrlPkg::stIdle;
    endcase
  end

  // one strobe per stage state
  assign fetchEn  = (state == ctrlPkg::stFetch);
  assign decodeEn = (state == ctrlPkg::stDecode);
  assign execEn   = (state == ctrlPkg::stExecute);
  assign memEn    = (state == ctrlPkg::stMemory);
  assign wbEn     = (state == ctrlPkg::stWriteBack);

  assign pcClear = start && stopped;  // new run starts at address 0
  assign busy    = !stopped;
  assign halted  = (state == ctrlPkg::stHalt);

endmodule

// ==== source/dataMemory.sv ====
`timescale 1ns/1ps
`include "procCore_settings.svh"

module dataMemory
(
  input  logic         clk,
  input  logic         rst,
  input  logic         memEn,     // memory state strobe
  input  logic         memWrite,
  input  logic [7:0]   addr,
  input  isaPkg::wordT wrData,
  output isaPkg::wordT rdData
);

  isaPkg::wordT mem [`DMEM_DEPTH];

  // whole array cleared on reset
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < `DMEM_DEPTH; i++)
        mem[i] <= '0;
    end
    else if (memEn && memWrite)
      mem[addr] <= wrData;
  end

  assign rdData = mem[addr];  // asynchronous read

endmodule

// ==== source/aluExecute.sv ====
`timescale 1ns/1ps
`include "procCore_settings.svh"

module aluExecute
(
  input  logic           clk,
  input  logic           rst,
  input  logic           execEn,
  input  isaPkg::opcodeT opcode,
  input  isaPkg::wordT   opA,
  input  isaPkg::wordT   opB,
  input  isaPkg::wordT   imm,
  input  logic           useImm,
  output isaPkg::wordT   aluOut,
  output isaPkg::flagsT  ccr
);

  isaPkg::wordT      opSrc;     // second operand
  logic [`DATA_W:0]  sum;       // extra bit holds carry or borrow
  logic              carryOut;
  logic              isAluOp;   // opcode updates the flags

  assign opSrc = useImm ? imm : opB;

  always_comb
  begin
    sum      = '0;
    carryOut = 1'b0;
    isAluOp  = 1'b1;
    aluOut   = opA;  // mov, ld, st and out pass rs
    case (opcode)
      isaPkg::opAdd, isaPkg::opAddi:
      begin
        sum      = {1'b0, opA} + {1'b0, opSrc};
        aluOut   = sum[`DATA_W-1:0];
        carryOut = sum[`DATA_W];
      end
      isaPkg::opSub:
      begin
        sum      = {1'b0, opA} - {1'b0, opSrc};
        aluOut   = sum[`DATA_W-1:0];
        carryOut = sum[`DATA_W];  // borrow
      end
      isaPkg::opAnd: aluOut = opA & opSrc;
      isaPkg::opOr:  aluOut = opA | opSrc;
      isaPkg::opNot: aluOut = ~opA;
      isaPkg::opShl:
      begin
        aluOut   = {opA[`DATA_W-2:0], 1'b0};
        carryOut = opA[`DATA_W-1];  // bit shifted out
      end
      isaPkg::opShr:
      begin
        aluOut   = {1'b0, opA[`DATA_W-1:1]};
        carryOut = opA[0];
      end
      isaPkg::opLdi:
      begin
        aluOut  = opSrc;
        isAluOp = 1'b0;
      end
      default: isAluOp = 1'b0;
    endcase
  end

  // flags held until the next alu opcode, logic ops clear carry
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ccr <= '0;
    else if (execEn && isAluOp)
    begin
      ccr.zero     <= (aluOut == '0);
      ccr.negative <= aluOut[`DATA_W-1];
      ccr.carry    <= carryOut;
    end
  end

endmodule

// ==== source/regDecode.sv ====
`timescale 1ns/1ps
`include "procCore_settings.svh"

module regDecode
(
  input  logic            clk,
  input  logic            rst,
  input  isaPkg::wordT    instr,
  input  logic            wbEn,      // register write strobe
  input  isaPkg::regIdxT  wbAddr,
  input  isaPkg::wordT    wbData,
  output isaPkg::opcodeT  opcode,
  output isaPkg::wordT    opA,
  output isaPkg::wordT    opB,
  output isaPkg::wordT    imm,
  output isaPkg::regIdxT  rdAddr,
  output logic            regWrite,
  output logic            memRead,
  output logic            memWrite,
  output logic            useImm,
  output logic            isOut,
  output logic            isHalt,
  output ctrlPkg::wbSelT  wbSel
);

  isaPkg::wordT   regFile [`REG_N];
  logic [4:0]     rawOp;
  isaPkg::regIdxT rsAddr;
  isaPkg::regIdxT rtAddr;
  isaPkg::regIdxT aIdx;  // read port a address
  isaPkg::regIdxT bIdx;  // read port b address

  // instruction fields
  assign rawOp  = instr[15:11];
  assign rdAddr = instr[10:8];
  assign rsAddr = instr[7:5];
  assign rtAddr = instr[4:2];
  assign imm    = {{(`DATA_W-8){instr[7]}}, instr[7:0]};  // sign extended

  // unused codes fall back to nop
  assign opcode = (rawOp > 5'(isaPkg::opHlt)) ? isaPkg::opNop : isaPkg::opcodeT'(rawOp);

  // addi reads rd on both ports, st reads rd as store data
  assign aIdx = (opcode == isaPkg::opAddi) ? rdAddr : rsAddr;
  assign bIdx = (opcode == isaPkg::opAddi || opcode == isaPkg::opSt) ? rdAddr : rtAddr;
  assign opA  = regFile[aIdx];
  assign opB  = regFile[bIdx];

  // control per opcode
  always_comb
  begin
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    useImm   = 1'b0;
    isOut    = 1'b0;
    isHalt   = 1'b0;
    wbSel    = ctrlPkg::wbAlu;
    case (opcode)
      isaPkg::opMov, isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd,
      isaPkg::opOr, isaPkg::opNot, isaPkg::opShl, isaPkg::opShr:
        regWrite = 1'b1;
      isaPkg::opLdi, isaPkg::opAddi:
      begin
        regWrite = 1'b1;
        useImm   = 1'b1;  // second operand from imm8
      end
      isaPkg::opLd:
      begin
        regWrite = 1'b1;
        memRead  = 1'b1;
        wbSel    = ctrlPkg::wbMem;
      end
      isaPkg::opSt:  memWrite = 1'b1;
      isaPkg::opOut: isOut    = 1'b1;
      isaPkg::opHlt: isHalt   = 1'b1;
      default: ;  // nop
    endcase
  end

  // register file, one synchronous write port
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < `REG_N; i++)
        regFile[i] <= '0;
    end
    else if (wbEn)
      regFile[wbAddr] <= wbData;
  end

endmodule

// ==== source/instrFetch.sv ====
`timescale 1ns/1ps
`include "procCore_settings.svh"

module instrFetch
(
  input  logic         clk,
  input  logic         rst,
  input  logic         fetchEn,
  input  logic         pcClear,   // run start
  input  logic         progWe,    // already gated with busy in the top
  input  logic [7:0]   progAddr,
  input  isaPkg::wordT progData,
  output isaPkg::wordT instr      // acts as the fetch/decode register
);

  isaPkg::wordT imem [`IMEM_DEPTH];  // program store, loaded from outside
  logic [7:0]   pc;

  // pc wraps at the top of the program store
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pc <= '0;
    else if (pcClear)
      pc <= '0;
    else if (fetchEn)
      pc <= pc + 8'd1;  // next word
  end

  // load port write and registered instruction read
  always_ff @(posedge clk)
  begin
    if (progWe)
      imem[progAddr] <= progData;
    if (fetchEn)
      instr <= imem[pc];  // valid from the decode state on
  end

endmodule

// ==== source/ctrlPkg.sv ====
package ctrlPkg;

  // one state per stage plus idle and halt
  typedef enum logic [2:0] {
    stIdle      = 3'd0,
    stFetch     = 3'd1,
    stDecode    = 3'd2,
    stExecute   = 3'd3,
    stMemory    = 3'd4,
    stWriteBack = 3'd5,
    stHalt      = 3'd6
  } stateT;

  // source of the register file write data
  typedef enum logic {
    wbAlu = 1'b0,
    wbMem = 1'b1
  } wbSelT;

endpackage

// ==== source/isaPkg.sv ====
`include "procCore_settings.svh"

package isaPkg;

  typedef logic [`DATA_W-1:0] wordT;  // data or instruction word
  typedef logic [2:0] regIdxT;        // r0..r7

  // condition codes, zero in the msb
  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
  } flagsT;

  // instr[15:11], codes above opHlt decode as nop
  typedef enum logic [4:0] {
    opNop  = 5'd0,
    opMov  = 5'd1,   // rd = rs
    opAdd  = 5'd2,   // rd = rs + rt
    opSub  = 5'd3,   // rd = rs - rt
    opAnd  = 5'd4,
    opOr   = 5'd5,
    opNot  = 5'd6,   // rd = ~rs
    opShl  = 5'd7,   // rd = rs << 1
    opShr  = 5'd8,   // rd = rs >> 1
    opLdi  = 5'd9,   // rd = sext(imm8)
    opAddi = 5'd10,  // rd = rd + sext(imm8)
    opLd   = 5'd11,  // rd = mem[rs]
    opSt   = 5'd12,  // mem[rs] = rd
    opOut  = 5'd13,  // port = rs
    opHlt  = 5'd14
  } opcodeT;

endpackage

// ==== source/procCore_settings.svh ====
`ifndef PROCCORE_SETTINGS_SVH
`define PROCCORE_SETTINGS_SVH

// datapath and instruction word width
`define DATA_W 16

// general purpose registers, indexed by 3 instruction bits
`define REG_N 8

// program store, addressed by the 8 bit pc
`define IMEM_DEPTH 256

// data RAM, addressed by the low byte of rs
`define DMEM_DEPTH 256

`endif
